// File: verilog/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

`define MIPS_DATA_WIDTH      32
`define MIPS_ADDR_WIDTH      16
`define MIPS_REG_ADDR_WIDTH  5
`define MIPS_RESET_PC        16'h0000

// opcode field, inst[31:26]
`define MIPS_OP_RTYPE  6'h00
`define MIPS_OP_J      6'h02
`define MIPS_OP_BEQ    6'h04
`define MIPS_OP_BNE    6'h05
`define MIPS_OP_ADDIU  6'h09
`define MIPS_OP_ANDI   6'h0c
`define MIPS_OP_ORI    6'h0d
`define MIPS_OP_LUI    6'h0f

// funct field, inst[5:0]
`define MIPS_FN_ADDU   6'h21
`define MIPS_FN_SUBU   6'h23
`define MIPS_FN_AND    6'h24
`define MIPS_FN_OR     6'h25
`define MIPS_FN_XOR    6'h26
`define MIPS_FN_SLT    6'h2a

`endif

// File: verilog/mips_pkg.sv
`include "mips_cfg.svh"

package mips_pkg;

    ////////////////////////////////////////////////////////////
    // alu operations
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,  // signed compare
        ALU_LUI = 4'd6,  // b into upper half
        ALU_EQ  = 4'd7,  // beq outcome
        ALU_NE  = 4'd8   // bne outcome
    } alu_op_t;

    ////////////////////////////////////////////////////////////
    // stage payloads
    ////////////////////////////////////////////////////////////

    // fetch to decode
    typedef struct packed {
        logic [`MIPS_ADDR_WIDTH-1:0] pc;
        logic [`MIPS_DATA_WIDTH-1:0] inst;
    } fetch_t;

    // decode to execute, operands already forwarded
    typedef struct packed {
        logic [`MIPS_ADDR_WIDTH-1:0]     pc;
        alu_op_t                         alu_op;
        logic [`MIPS_DATA_WIDTH-1:0]     op_a;
        logic [`MIPS_DATA_WIDTH-1:0]     op_b;    // rt or immediate
        logic [`MIPS_REG_ADDR_WIDTH-1:0] rd;
        logic                            wb_reg;
        logic                            branch;
        logic                            jump;
        logic [`MIPS_ADDR_WIDTH-1:0]     target;
    } dec_t;

    // register write, also the retire port
    typedef struct packed {
        logic                            valid;
        logic [`MIPS_REG_ADDR_WIDTH-1:0] addr;
        logic [`MIPS_DATA_WIDTH-1:0]     data;
    } wb_t;

endpackage

// File: verilog/pipe_reg.sv
module pipe_reg #(
    parameter type payload_t = logic
)(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid_out,
    output payload_t data_out
);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid_out <= 1'b0;
        else if (!stall)
            valid_out <= flush ? 1'b0 : valid_in; // flush leaves a bubble
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
            data_out <= data_in;
    end

endmodule

// File: verilog/fetch_unit.sv
`include "mips_cfg.svh"

module fetch_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,
    input  logic                        redirect,
    input  logic [`MIPS_ADDR_WIDTH-1:0] target,
    output logic [`MIPS_ADDR_WIDTH-1:0] pc
);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc <= `MIPS_RESET_PC;
        end
        else if (redirect)
        begin
            pc <= target; // taken branch or j from execute
        end
        else if (!stall)
        begin
            pc <= pc + `MIPS_ADDR_WIDTH'(4);
        end
    end

endmodule

// File: verilog/decoder.sv
`include "mips_cfg.svh"

module decoder (
    input  logic [`MIPS_DATA_WIDTH-1:0]     inst,
    input  logic [`MIPS_ADDR_WIDTH-1:0]     pc,
    output logic [`MIPS_REG_ADDR_WIDTH-1:0] rs,
    output logic [`MIPS_REG_ADDR_WIDTH-1:0] rt,
    output logic                            rs_used,
    output logic                            rt_used,
    output mips_pkg::alu_op_t               alu_op,
    output logic                            use_imm,
    output logic [`MIPS_DATA_WIDTH-1:0]     imm,
    output logic [`MIPS_REG_ADDR_WIDTH-1:0] rd,
    output logic                            wb_reg,
    output logic                            branch,
    output logic                            jump,
    output logic [`MIPS_ADDR_WIDTH-1:0]     target
);

    logic [5:0]                  opcode;
    logic [5:0]                  funct;
    logic [15:0]                 imm16;
    logic [`MIPS_DATA_WIDTH-1:0] imm_sext;
    logic [`MIPS_DATA_WIDTH-1:0] imm_zext;
    logic [`MIPS_ADDR_WIDTH-1:0] br_target;
    logic [`MIPS_ADDR_WIDTH-1:0] j_target;

    assign opcode   = inst[31:26];
    assign funct    = inst[5:0];
    assign imm16    = inst[15:0];
    assign rs       = inst[25:21];
    assign rt       = inst[20:16];
    assign imm_sext = {{16{imm16[15]}}, imm16};
    assign imm_zext = {16'h0000, imm16};

    // pc+4 plus word offset, upper bits fall off the address width
    assign br_target = pc + `MIPS_ADDR_WIDTH'(4)
                     + `MIPS_ADDR_WIDTH'({imm_sext[`MIPS_ADDR_WIDTH-3:0], 2'b00});
    assign j_target  = {inst[`MIPS_ADDR_WIDTH-3:0], 2'b00};

    always_comb
    begin
        rs_used = 1'b0;
        rt_used = 1'b0;
        alu_op  = mips_pkg::ALU_ADD;
        use_imm = 1'b1;
        imm     = imm_sext;
        rd      = rt;        // I-type default
        wb_reg  = 1'b0;
        branch  = 1'b0;
        jump    = 1'b0;
        target  = br_target;

        case (opcode)
            `MIPS_OP_RTYPE:
            begin
                rd      = inst[15:11];
                use_imm = 1'b0;
                rs_used = 1'b1;
                rt_used = 1'b1;
                wb_reg  = 1'b1;
                case (funct)
                    `MIPS_FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    `MIPS_FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    `MIPS_FN_AND:  alu_op = mips_pkg::ALU_AND;
                    `MIPS_FN_OR:   alu_op = mips_pkg::ALU_OR;
                    `MIPS_FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                    `MIPS_FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    default:       wb_reg = 1'b0; // unknown funct, no-op
                endcase
            end
            `MIPS_OP_ADDIU:
            begin
                rs_used = 1'b1;
                wb_reg  = 1'b1;
            end
            `MIPS_OP_ANDI, `MIPS_OP_ORI:
            begin
                alu_op  = (opcode == `MIPS_OP_ANDI) ? mips_pkg::ALU_AND : mips_pkg::ALU_OR;
                imm     = imm_zext;
                rs_used = 1'b1;
                wb_reg  = 1'b1;
            end
            `MIPS_OP_LUI:
            begin
                alu_op = mips_pkg::ALU_LUI;
                imm    = imm_zext;
                wb_reg = 1'b1;
            end
            `MIPS_OP_BEQ, `MIPS_OP_BNE:
            begin
                alu_op  = (opcode == `MIPS_OP_BEQ) ? mips_pkg::ALU_EQ : mips_pkg::ALU_NE;
                use_imm = 1'b0;
                rs_used = 1'b1;
                rt_used = 1'b1;
                branch  = 1'b1;
            end
            `MIPS_OP_J:
            begin
                jump   = 1'b1;
                target = j_target;
            end
            default: ; // no-op
        endcase
    end

endmodule

// File: verilog/register_file.sv
`include "mips_cfg.svh"

module register_file (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] rs,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] rt,
    output logic [`MIPS_DATA_WIDTH-1:0]     rs_data,
    output logic [`MIPS_DATA_WIDTH-1:0]     rt_data,
    input  mips_pkg::wb_t                   wb
);

    localparam int NUM_REGS = 1 << `MIPS_REG_ADDR_WIDTH;

    logic [`MIPS_DATA_WIDTH-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wb.valid)
        begin
            regs[wb.addr] <= wb.data;
        end
    end

    // r0 hardwired
    assign rs_data = (rs == '0) ? '0 : regs[rs];
    assign rt_data = (rt == '0) ? '0 : regs[rt];

endmodule

// File: verilog/forwarding_unit.sv
`include "mips_cfg.svh"

module forwarding_unit (
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] rs,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] rt,
    input  logic                            rs_used,
    input  logic                            rt_used,
    input  logic [`MIPS_DATA_WIDTH-1:0]     rs_data,
    input  logic [`MIPS_DATA_WIDTH-1:0]     rt_data,
    input  mips_pkg::wb_t                   ex_result,
    input  mips_pkg::wb_t                   wb,
    output logic [`MIPS_DATA_WIDTH-1:0]     op_a,
    output logic [`MIPS_DATA_WIDTH-1:0]     op_b
);

    // newest producer wins, execute before writeback
    function automatic logic [`MIPS_DATA_WIDTH-1:0] select_src(
        input logic [`MIPS_REG_ADDR_WIDTH-1:0] src,
        input logic                            used,
        input logic [`MIPS_DATA_WIDTH-1:0]     rf_val,
        input mips_pkg::wb_t                   ex_w,
        input mips_pkg::wb_t                   wb_w
    );
        if (!used || src == '0)
            return rf_val;
        if (ex_w.valid && ex_w.addr == src)
            return ex_w.data;
        if (wb_w.valid && wb_w.addr == src)
            return wb_w.data;
        return rf_val;
    endfunction

    assign op_a = select_src(rs, rs_used, rs_data, ex_result, wb);
    assign op_b = select_src(rt, rt_used, rt_data, ex_result, wb);

endmodule

// File: verilog/alu.sv
`include "mips_cfg.svh"

module alu (
    input  mips_pkg::alu_op_t           op,
    input  logic [`MIPS_DATA_WIDTH-1:0] a,
    input  logic [`MIPS_DATA_WIDTH-1:0] b,
    output logic [`MIPS_DATA_WIDTH-1:0] result,
    output logic                        taken
);

    localparam int HALF = `MIPS_DATA_WIDTH / 2;

    logic equal;

    assign equal = (a == b);

    always_comb
    begin
        result = '0;
        taken  = 1'b0;
        case (op)
            mips_pkg::ALU_ADD: result = a + b;
            mips_pkg::ALU_SUB: result = a - b;
            mips_pkg::ALU_AND: result = a & b;
            mips_pkg::ALU_OR:  result = a | b;
            mips_pkg::ALU_XOR: result = a ^ b;
            mips_pkg::ALU_SLT:
            begin
                result = {{(`MIPS_DATA_WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
            end
            mips_pkg::ALU_LUI:
            begin
                result = {b[HALF-1:0], {HALF{1'b0}}};
            end
            // branch compares give no result
            mips_pkg::ALU_EQ: taken = equal;
            mips_pkg::ALU_NE: taken = !equal;
            default: ;
        endcase
    end

endmodule

// File: verilog/mips_cpu.sv
`include "mips_cfg.svh"

module mips_cpu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        run,
    output logic [`MIPS_ADDR_WIDTH-1:0] imem_addr,
    input  logic [`MIPS_DATA_WIDTH-1:0] imem_data,
    output mips_pkg::wb_t               wb
);

    logic stall;
    logic redirect;

    // fetch2dec
    mips_pkg::fetch_t fetch_in;
    mips_pkg::fetch_t dec_q;
    logic             dec_valid;

    // decode
    logic [`MIPS_REG_ADDR_WIDTH-1:0] rs;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] rt;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] rd;
    logic                            rs_used;
    logic                            rt_used;
    logic                            use_imm;
    logic                            wb_reg;
    logic                            branch;
    logic                            jump;
    mips_pkg::alu_op_t               alu_op;
    logic [`MIPS_DATA_WIDTH-1:0]     imm;
    logic [`MIPS_DATA_WIDTH-1:0]     rs_data;
    logic [`MIPS_DATA_WIDTH-1:0]     rt_data;
    logic [`MIPS_DATA_WIDTH-1:0]     fwd_a;
    logic [`MIPS_DATA_WIDTH-1:0]     fwd_b;
    logic [`MIPS_ADDR_WIDTH-1:0]     target;
    mips_pkg::dec_t                  dec_out;

    // dec2exec
    mips_pkg::dec_t              ex_q;
    logic                        ex_valid;
    logic [`MIPS_DATA_WIDTH-1:0] alu_result;
    logic                        alu_taken;
    mips_pkg::wb_t               ex_result;

    // exec2wb
    mips_pkg::wb_t wb_q;
    logic          wb_valid;

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    assign stall    = !run;  // outside holds the whole core
    assign redirect = ex_valid && ((ex_q.branch && alu_taken) || ex_q.jump);

    ////////////////////////////////////////////////////////////
    // fetch
    ////////////////////////////////////////////////////////////

    fetch_unit fetch (.clk(clk), .rst_n(rst_n), .stall(stall), .redirect(redirect),
                      .target(ex_q.target), .pc(imem_addr));

    assign fetch_in = '{pc: imem_addr, inst: imem_data};

    pipe_reg #(.payload_t(mips_pkg::fetch_t)) pfd (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(redirect),
        .valid_in(1'b1), .data_in(fetch_in), .valid_out(dec_valid), .data_out(dec_q));

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    decoder decode (.inst(dec_q.inst), .pc(dec_q.pc), .rs(rs), .rt(rt), .rs_used(rs_used),
                    .rt_used(rt_used), .alu_op(alu_op), .use_imm(use_imm), .imm(imm), .rd(rd),
                    .wb_reg(wb_reg), .branch(branch), .jump(jump), .target(target));

    register_file regfile (.clk(clk), .rst_n(rst_n), .rs(rs), .rt(rt),
                           .rs_data(rs_data), .rt_data(rt_data), .wb(wb));

    forwarding_unit forward (.rs(rs), .rt(rt), .rs_used(rs_used), .rt_used(rt_used),
                             .rs_data(rs_data), .rt_data(rt_data), .ex_result(ex_result),
                             .wb(wb), .op_a(fwd_a), .op_b(fwd_b));

    assign dec_out = '{pc: dec_q.pc, alu_op: alu_op, op_a: fwd_a,
                       op_b: use_imm ? imm : fwd_b, rd: rd, wb_reg: wb_reg,
                       branch: branch, jump: jump, target: target};

    pipe_reg #(.payload_t(mips_pkg::dec_t)) pde (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(redirect),
        .valid_in(dec_valid), .data_in(dec_out), .valid_out(ex_valid), .data_out(ex_q));

    ////////////////////////////////////////////////////////////
    // execute
    ////////////////////////////////////////////////////////////

    alu alu_i (.op(ex_q.alu_op), .a(ex_q.op_a), .b(ex_q.op_b),
               .result(alu_result), .taken(alu_taken));

    // r0 targets never leave execute
    assign ex_result = '{valid: ex_valid && ex_q.wb_reg && (ex_q.rd != '0),
                         addr: ex_q.rd, data: alu_result};

    pipe_reg #(.payload_t(mips_pkg::wb_t)) pew (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(1'b0),
        .valid_in(ex_result.valid), .data_in(ex_result), .valid_out(wb_valid), .data_out(wb_q));

    // writeback, held back while stalled
    assign wb = '{valid: wb_valid && run, addr: wb_q.addr, data: wb_q.data};

endmodule

// File: testbench/mips_cpu_assert.sv
`include "mips_cfg.svh"

module mips_cpu_assert (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        run,
    input logic [`MIPS_ADDR_WIDTH-1:0] imem_addr,
    input mips_pkg::wb_t               wb
);

    int unsigned fails = 0;

    r0_never_written: assert property (
        @(posedge clk) disable iff (!rst_n) wb.valid |-> (wb.addr != '0))
    else
    begin
        fails++;
        $error("writeback shows register 0");
    end

    quiet_while_held: assert property (
        @(posedge clk) disable iff (!rst_n) !run |-> !wb.valid)
    else
    begin
        fails++;
        $error("writeback valid while run is low");
    end

    // fetch address known and word aligned
    fetch_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(imem_addr) && imem_addr[1:0] == 2'b00)
    else
    begin
        fails++;
        $error("fetch address unknown or not word aligned");
    end

endmodule

bind mips_cpu mips_cpu_assert checks (
    .clk(clk), .rst_n(rst_n), .run(run), .imem_addr(imem_addr), .wb(wb));

// File: testbench/tb_mips_cpu.sv
`include "mips_cfg.svh"

module tb_mips_cpu;

    localparam int IMEM_WORDS = 256;
    localparam int MAX_CYCLES = 3000;

    logic                        clk;
    logic                        rst_n;
    logic                        run;
    logic [`MIPS_ADDR_WIDTH-1:0] imem_addr;
    logic [`MIPS_DATA_WIDTH-1:0] imem_data;
    mips_pkg::wb_t               wb;

    logic [`MIPS_DATA_WIDTH-1:0] imem [IMEM_WORDS];
    mips_pkg::wb_t               exp_q [$];  // register writes still to come
    mips_pkg::wb_t               exp_w;
    integer                      seed;
    int                          errors;
    int                          cycles;

    always #4 clk = ~clk;

    assign imem_data = imem[imem_addr[9:2]];  // same-cycle instruction port

    mips_cpu DUT (.clk(clk), .rst_n(rst_n), .run(run), .imem_addr(imem_addr),
                  .imem_data(imem_data), .wb(wb));

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES)
        begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // retire monitor
    always @(posedge clk)
    begin
        if (rst_n && wb.valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("unexpected write of %h to r%0d at time %0t", wb.data, wb.addr, $time);
                errors++;
            end
            else
            begin
                exp_w = exp_q.pop_front();
                check_value(32'(wb.addr), 32'(exp_w.addr), "write address");
                check_value(wb.data, exp_w.data, "write data");
            end
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rd, rs, rt);
        return {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt, rs,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [15:0] addr);
        return {`MIPS_OP_J, 12'd0, addr[15:2]};
    endfunction

    ////////////////////////////////////////////////////////////
    // ISA reference model
    ////////////////////////////////////////////////////////////

    task automatic build_expected;
        logic [31:0] regs [32];
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [15:0] pc;
        logic [15:0] nxt;
        logic [4:0]  dst;
        logic        wr;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        exp_q.delete();
        pc = `MIPS_RESET_PC;
        for (int step = 0; step < 500; step++)
        begin
            inst = imem[pc[9:2]];
            a    = regs[inst[25:21]];
            b    = regs[inst[20:16]];
            nxt  = pc + 16'd4;  // no delay slot
            dst  = inst[20:16];
            wr   = 1'b1;
            v    = '0;
            case (inst[31:26])
                `MIPS_OP_RTYPE:
                begin
                    dst = inst[15:11];
                    case (inst[5:0])
                        `MIPS_FN_ADDU: v = a + b;
                        `MIPS_FN_SUBU: v = a - b;
                        `MIPS_FN_AND:  v = a & b;
                        `MIPS_FN_OR:   v = a | b;
                        `MIPS_FN_XOR:  v = a ^ b;
                        `MIPS_FN_SLT:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:       wr = 1'b0;
                    endcase
                end
                `MIPS_OP_ADDIU: v = a + {{16{inst[15]}}, inst[15:0]};
                `MIPS_OP_ANDI:  v = a & {16'h0000, inst[15:0]};
                `MIPS_OP_ORI:   v = a | {16'h0000, inst[15:0]};
                `MIPS_OP_LUI:   v = {inst[15:0], 16'h0000};
                `MIPS_OP_BEQ, `MIPS_OP_BNE:
                begin
                    wr = 1'b0;
                    if ((a == b) == (inst[31:26] == `MIPS_OP_BEQ))
                        nxt = pc + 16'd4 + {inst[13:0], 2'b00};
                end
                `MIPS_OP_J:
                begin
                    wr  = 1'b0;
                    nxt = {inst[13:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0)
            begin
                regs[dst] = v;
                exp_q.push_back('{valid: 1'b1, addr: dst, data: v});
            end
            if (nxt == pc)
                break;  // self-jump ends the program
            pc = nxt;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequencing
    ////////////////////////////////////////////////////////////

    task automatic start_test;
        @(posedge clk);
        rst_n <= 1'b0;
        run   <= 1'b0;
        @(negedge clk);
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = '0;
    endtask

    task automatic release_reset;
        build_expected();
        repeat (10)
        begin
            @(posedge clk);
            check_value(32'(imem_addr), `MIPS_RESET_PC, "fetch address in reset");
            check_value(32'(wb.valid), 32'd0, "wb valid in reset");
        end
        rst_n <= 1'b1;
        run   <= 1'b1;
    endtask

    task automatic wait_drain;
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 400)
        begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0)
        begin
            $display("%0d expected register writes never appeared by time %0t",
                     exp_q.size(), $time);
            errors++;
            exp_q.delete();
        end
        repeat (8) @(posedge clk);  // window for stray writes
    endtask

    task automatic load_branches;
        imem[0]  = enc_i(`MIPS_OP_ADDIU, 5'd1, 5'd0, 16'd5);
        imem[1]  = enc_i(`MIPS_OP_ADDIU, 5'd2, 5'd0, 16'd5);
        imem[2]  = enc_i(`MIPS_OP_BEQ, 5'd2, 5'd1, 16'd2);        // taken, to 20
        imem[3]  = enc_i(`MIPS_OP_ADDIU, 5'd10, 5'd0, 16'h0bad);
        imem[4]  = enc_i(`MIPS_OP_ADDIU, 5'd11, 5'd0, 16'h0bad);
        imem[5]  = enc_i(`MIPS_OP_ADDIU, 5'd3, 5'd0, 16'h0111);
        imem[6]  = enc_i(`MIPS_OP_BNE, 5'd2, 5'd1, 16'd1);        // not taken
        imem[7]  = enc_i(`MIPS_OP_ADDIU, 5'd4, 5'd0, 16'h0222);
        imem[8]  = enc_j(16'd44);
        imem[9]  = enc_i(`MIPS_OP_ADDIU, 5'd12, 5'd0, 16'h0bad);
        imem[10] = enc_i(`MIPS_OP_ADDIU, 5'd13, 5'd0, 16'h0bad);
        imem[11] = enc_i(`MIPS_OP_ADDIU, 5'd5, 5'd0, 16'h0333);
        imem[12] = enc_i(`MIPS_OP_BEQ, 5'd0, 5'd0, 16'd1);
        imem[13] = enc_i(`MIPS_OP_ADDIU, 5'd14, 5'd0, 16'h0bad);
        imem[14] = enc_j(16'd56);
    endtask

    task automatic reset_and_first_write;
        start_test();
        imem[0] = enc_i(`MIPS_OP_ADDIU, 5'd1, 5'd0, 16'h0055);
        imem[1] = enc_j(16'd4);
        release_reset();
        @(posedge clk);
        check_value(32'(imem_addr), `MIPS_RESET_PC, "first fetch address");
        check_value(32'(wb.valid), 32'd0, "wb valid after reset");
        repeat (2) @(posedge clk);
        check_value(32'(wb.valid), 32'd0, "wb valid two edges after fetch");
        @(posedge clk);
        check_value(32'(wb.valid), 32'd1, "wb valid three edges after fetch");
        wait_drain();
    endtask

    task automatic dependent_chain;
        start_test();
        imem[0]  = enc_i(`MIPS_OP_LUI, 5'd1, 5'd0, 16'h8001);
        imem[1]  = enc_i(`MIPS_OP_ORI, 5'd1, 5'd1, 16'h00f0);
        imem[2]  = enc_i(`MIPS_OP_ADDIU, 5'd2, 5'd1, 16'hfff0);
        imem[3]  = enc_r(`MIPS_FN_SUBU, 5'd3, 5'd2, 5'd1);
        imem[4]  = enc_r(`MIPS_FN_AND, 5'd4, 5'd3, 5'd1);
        imem[5]  = enc_r(`MIPS_FN_OR, 5'd5, 5'd4, 5'd2);
        imem[6]  = enc_r(`MIPS_FN_XOR, 5'd6, 5'd5, 5'd3);
        imem[7]  = enc_r(`MIPS_FN_SLT, 5'd7, 5'd1, 5'd6);
        imem[8]  = enc_r(`MIPS_FN_SLT, 5'd8, 5'd6, 5'd1);
        imem[9]  = enc_i(`MIPS_OP_ANDI, 5'd9, 5'd3, 16'h0ff0);
        imem[10] = enc_r(`MIPS_FN_ADDU, 5'd10, 5'd9, 5'd7);
        imem[11] = enc_r(`MIPS_FN_ADDU, 5'd0, 5'd10, 5'd10);  // dropped
        imem[12] = enc_r(`MIPS_FN_ADDU, 5'd11, 5'd0, 5'd10);
        imem[13] = enc_j(16'd52);
        release_reset();
        wait_drain();
    endtask

    task automatic branch_and_jump;
        start_test();
        load_branches();
        release_reset();
        wait_drain();
    endtask

    task automatic run_held;
        int n;
        start_test();
        load_branches();
        release_reset();
        n = 0;
        while (exp_q.size() != 0 && n < 100)
        begin
            run <= 1'b1;
            repeat (1 + {$random(seed)} % 6) @(posedge clk);
            run <= 1'b0;
            repeat (1 + {$random(seed)} % 5) @(posedge clk);
            n++;
        end
        run <= 1'b1;
        wait_drain();
    endtask

    task automatic load_random;
        logic [4:0]  d;
        logic [4:0]  s;
        logic [4:0]  t;
        logic [15:0] imm;
        int          k;
        for (int i = 0; i < 60; i++)
        begin
            d   = 5'({$random(seed)} % 8);  // few registers, many hazards
            s   = 5'({$random(seed)} % 8);
            t   = 5'({$random(seed)} % 8);
            imm = 16'($random(seed));
            k   = {$random(seed)} % 10;
            case (k)
                0: imem[i] = enc_r(`MIPS_FN_ADDU, d, s, t);
                1: imem[i] = enc_r(`MIPS_FN_SUBU, d, s, t);
                2: imem[i] = enc_r(`MIPS_FN_AND, d, s, t);
                3: imem[i] = enc_r(`MIPS_FN_OR, d, s, t);
                4: imem[i] = enc_r(`MIPS_FN_XOR, d, s, t);
                5: imem[i] = enc_r(`MIPS_FN_SLT, d, s, t);
                6: imem[i] = enc_i(`MIPS_OP_ADDIU, d, s, imm);
                7: imem[i] = enc_i(`MIPS_OP_ANDI, d, s, imm);
                8: imem[i] = enc_i(`MIPS_OP_ORI, d, s, imm);
                default: imem[i] = enc_i(`MIPS_OP_LUI, d, s, imm);
            endcase
        end
        imem[60] = enc_j(16'd240);
    endtask

    task automatic random_programs;
        repeat (3)
        begin
            start_test();
            load_random();
            release_reset();
            wait_drain();
        end
    endtask

    initial
    begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        run    = 1'b0;
        seed   = 71545;
        errors = 0;
        cycles = 0;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = '0;
        reset_and_first_write();
        dependent_chain();
        branch_and_jump();
        run_held();
        random_programs();
        $display("%0d errors, %0d assertion failures", errors, DUT.checks.fails);
        if (errors == 0 && DUT.checks.fails == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: src.f
+incdir+verilog
verilog/mips_pkg.sv
verilog/pipe_reg.sv
verilog/fetch_unit.sv
verilog/decoder.sv
verilog/register_file.sv
verilog/forwarding_unit.sv
verilog/alu.sv
verilog/mips_cpu.sv
testbench/mips_cpu_assert.sv
testbench/tb_mips_cpu.sv

// File: Bender.yml
package:
  name: mips_cpu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mips_pkg.sv
      - verilog/pipe_reg.sv
      - verilog/fetch_unit.sv
      - verilog/decoder.sv
      - verilog/register_file.sv
      - verilog/forwarding_unit.sv
      - verilog/alu.sv
      - verilog/mips_cpu.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/mips_cpu_assert.sv
      - testbench/tb_mips_cpu.sv
